// File: filelist.f
+incdir+source
source/qa_drv_pkg.sv
source/qa_csr_decoder.sv
source/qa_chan_fifo.sv
source/qa_drv_tester.sv
source/qa_status_mgr.sv
source/qa_drv_top.sv
verification/qa_drv_tb.sv

// File: Bender.yml
package:
  name: qa_drv

sources:
  - include_dirs:
      - source
    files:
      - source/qa_drv_pkg.sv
      - source/qa_csr_decoder.sv
      - source/qa_chan_fifo.sv
      - source/qa_drv_tester.sv
      - source/qa_status_mgr.sv
      - source/qa_drv_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/qa_drv_tb.sv

// File: verification/qa_drv_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed tests for the test node top level
// Inputs change on the falling edge, outputs are sampled there too
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "qa_drv_params.svh"

module qa_drv_tb;

    localparam int W       = `QA_UMF_WIDTH;
    localparam int TIMEOUT = 200;

    logic                clk;
    logic                resetb;
    logic                csr_wr_valid;
    logic [15:0]         csr_wr_addr;
    logic [63:0]         csr_wr_data;
    logic                host_rx_valid;
    logic [W-1:0]        host_rx_data;
    logic                host_rx_space;
    logic                host_tx_rdy;
    logic [W-1:0]        host_tx_data;
    logic                host_tx_enable;
    logic [W-1:0]        client_rx_data;
    logic                client_rx_rdy;
    logic                client_rx_enable;
    logic [W-1:0]        client_tx_data;
    logic                client_tx_rdy;
    logic                client_tx_enable;
    qa_drv_pkg::t_status status;

    integer seed;
    int     errors;
    int     checks;
    int     tests;

    qa_drv_top i_dut
    (
        .clk              (clk),
        .resetb           (resetb),
        .csr_wr_valid     (csr_wr_valid),
        .csr_wr_addr      (csr_wr_addr),
        .csr_wr_data      (csr_wr_data),
        .host_rx_valid    (host_rx_valid),
        .host_rx_data     (host_rx_data),
        .host_rx_space    (host_rx_space),
        .host_tx_rdy      (host_tx_rdy),
        .host_tx_data     (host_tx_data),
        .host_tx_enable   (host_tx_enable),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_rdy    (client_tx_rdy),
        .client_tx_enable (client_tx_enable),
        .status           (status)
    );

    // 40 unit period
    always #20 clk = ~clk;

    function automatic logic [W-1:0] rand_word();
        rand_word = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic check(input logic [W-1:0] got, input logic [W-1:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - err_start);
    endtask

    // Request strobe at edge N, pulse at N+1, mode change at N+2
    task automatic csr_write(input logic [15:0] addr, input logic [63:0] data);
        csr_wr_valid = 1'b1;
        csr_wr_addr  = addr;
        csr_wr_data  = data;
        @(negedge clk);
        csr_wr_valid = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    // Push on the host side, or on the client side when from_client is set
    task automatic push_word(input bit from_client, input logic [W-1:0] data);
        int t;
        t = 0;
        while (!(from_client ? client_tx_rdy : host_rx_space) && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!(from_client ? client_tx_rdy : host_rx_space))
            abort_run("no room to push a word");
        if (from_client)
        begin
            client_tx_data   = data;
            client_tx_enable = 1'b1;
        end
        else
        begin
            host_rx_data  = data;
            host_rx_valid = 1'b1;
        end
        @(negedge clk);
        client_tx_enable = 1'b0;
        host_rx_valid    = 1'b0;
    endtask

    // Pull from host_tx, or from client_rx when to_host is clear
    task automatic pull_word(input bit to_host, output logic [W-1:0] data);
        int t;
        t = 0;
        while (!(to_host ? host_tx_rdy : client_rx_rdy) && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (!(to_host ? host_tx_rdy : client_rx_rdy))
            abort_run("no word offered for a pull");
        data             = to_host ? host_tx_data : client_rx_data;
        host_tx_enable   = to_host;
        client_rx_enable = !to_host;
        @(negedge clk);
        host_tx_enable   = 1'b0;
        client_rx_enable = 1'b0;
    endtask

    task automatic wait_tests_done(input logic [15:0] target);
        int t;
        t = 0;
        while (status.tests_done != target && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (status.tests_done != target)
            abort_run("tests_done never reached its target");
    endtask

    task automatic normal_passthrough();
        logic [W-1:0] q[$];
        logic [W-1:0] w;
        logic [31:0]  rx_base;
        logic [31:0]  tx_base;
        int           err_start;
        int           i;
        err_start = errors;
        rx_base   = status.host_rx_msgs;
        tx_base   = status.host_tx_msgs;
        // Host to client, three words in order
        for (i = 0; i < 3; i++)
        begin
            w = rand_word();
            q.push_back(w);
            push_word(1'b0, w);
        end
        for (i = 0; i < 3; i++)
        begin
            pull_word(1'b0, w);
            check(w, q.pop_front(), "client_rx word order");
        end
        // Client to host
        for (i = 0; i < 3; i++)
        begin
            w = rand_word();
            q.push_back(w);
            push_word(1'b1, w);
        end
        for (i = 0; i < 3; i++)
        begin
            pull_word(1'b1, w);
            check(w, q.pop_front(), "host_tx word order");
        end
        check(status.host_rx_msgs - rx_base, 3, "host_rx_msgs count");
        check(status.host_tx_msgs - tx_base, 3, "host_tx_msgs count");
        end_test("normal_passthrough", err_start);
    endtask

    task automatic loopback_echo();
        logic [W-1:0] q[$];
        logic [W-1:0] w;
        logic [W-1:0] got;
        logic [15:0]  done_base;
        int           err_start;
        int           i;
        err_start = errors;
        done_base = status.tests_done;
        csr_write(`QA_CSR_ADDR_TEST, 64'(`QA_MODE_LOOPBACK));
        // Last word carries bit 0
        for (i = 0; i < 3; i++)
        begin
            w    = rand_word();
            w[0] = (i == 2);
            q.push_back(w);
            push_word(1'b0, w);
            check(client_rx_rdy, 0, "client_rx_rdy low in loopback");
            check(client_tx_rdy, 0, "client_tx_rdy low in loopback");
        end
        for (i = 0; i < 3; i++)
        begin
            pull_word(1'b1, w);
            check(w, q.pop_front(), "loopback word");
        end
        wait_tests_done(done_base + 1'b1);
        // Back in normal mode
        w = rand_word();
        push_word(1'b0, w);
        pull_word(1'b0, got);
        check(got, w, "pass-through after loopback");
        end_test("loopback_echo", err_start);
    endtask

    task automatic source_burst();
        logic [W-1:0] w;
        logic [W-1:0] exp;
        logic [31:0]  tx_base;
        logic [15:0]  done_base;
        int           err_start;
        int           n;
        int           k;
        err_start = errors;
        done_base = status.tests_done;
        tx_base   = status.host_tx_msgs;
        n         = 5;
        csr_write(`QA_CSR_ADDR_TEST, (64'(n) << 2) | 64'(`QA_MODE_SOURCE));
        for (k = 0; k < n; k++)
        begin
            // Remaining count above bit 0, last flag in bit 0
            exp = (W'(n - k) << 1) | W'(k == n - 1);
            pull_word(1'b1, w);
            check(w, exp, "source word");
        end
        wait_tests_done(done_base + 1'b1);
        @(negedge clk);
        check(host_tx_rdy, 0, "no extra source word");
        check(status.host_tx_msgs - tx_base, n, "source push count");
        end_test("source_burst", err_start);
    endtask

    task automatic sink_consume();
        logic [W-1:0] w;
        logic [31:0]  rx_base;
        logic [15:0]  done_base;
        int           err_start;
        int           i;
        err_start = errors;
        done_base = status.tests_done;
        rx_base   = status.host_rx_msgs;
        csr_write(`QA_CSR_ADDR_TEST, 64'(`QA_MODE_SINK));
        for (i = 0; i < 3; i++)
        begin
            w    = rand_word();
            w[0] = (i == 2);
            push_word(1'b0, w);
            check(client_rx_rdy, 0, "client_rx_rdy low in sink");
        end
        pull_word(1'b1, w);
        check(w, 1, "sink reply word");
        wait_tests_done(done_base + 1'b1);
        @(negedge clk);
        check(host_tx_rdy, 0, "single sink reply");
        check(client_rx_rdy, 0, "nothing left for the client");
        check(status.host_rx_msgs - rx_base, 3, "sink pop count");
        end_test("sink_consume", err_start);
    endtask

    task automatic backpressure_drain();
        logic [W-1:0] q[$];
        logic [W-1:0] w;
        logic [W-1:0] got;
        logic [15:0]  done_base;
        int           err_start;
        int           accepted;
        int           i;
        err_start = errors;
        done_base = status.tests_done;
        csr_write(`QA_CSR_ADDR_TEST, 64'(`QA_MODE_LOOPBACK));
        // Host leaves host_tx alone, so both FIFOs fill up
        for (i = 0; i < 2 * `QA_FIFO_DEPTH + 2; i++)
        begin
            w = rand_word() & ~W'(1);
            if (host_rx_space)
            begin
                push_word(1'b0, w);
                q.push_back(w);
            end
            else
                @(negedge clk);
        end
        accepted = q.size();
        check(accepted, 2 * `QA_FIFO_DEPTH, "words accepted while stalled");
        // Stalled: a word is offered, none taken, no room on the tx side
        check(status.dbg, {1'b1, 1'b0, 1'b0, 1'b0, `QA_MODE_LOOPBACK}, "dbg while stalled");
        for (i = 0; i < accepted; i++)
        begin
            pull_word(1'b1, w);
            check(w, q.pop_front(), "drained word order");
        end
        // Closing word ends the test
        w = rand_word() | W'(1);
        push_word(1'b0, w);
        pull_word(1'b1, got);
        check(got, w, "closing loopback word");
        wait_tests_done(done_base + 1'b1);
        end_test("backpressure_drain", err_start);
    endtask

    task automatic foreign_csr_write();
        qa_drv_pkg::t_afu_enable_test cfg_before;
        logic [W-1:0]                 w;
        logic [W-1:0]                 got;
        int                           err_start;
        err_start  = errors;
        cfg_before = status.last_cfg;
        // Loopback request with a count, at an undecoded address
        csr_write(16'h0020, (64'(9) << 2) | 64'(`QA_MODE_LOOPBACK));
        @(negedge clk);
        check(status.last_cfg, cfg_before, "last_cfg unchanged");
        check(status.dbg.mode, `QA_MODE_NORMAL, "mode stays normal");
        w = rand_word();
        push_word(1'b0, w);
        pull_word(1'b0, got);
        check(got, w, "pass-through after foreign write");
        end_test("foreign_csr_write", err_start);
    endtask

    initial
    begin
        seed             = 57;
        errors           = 0;
        checks           = 0;
        tests            = 0;
        clk              = 1'b0;
        resetb           = 1'b0;
        csr_wr_valid     = 1'b0;
        csr_wr_addr      = '0;
        csr_wr_data      = '0;
        host_rx_valid    = 1'b0;
        host_rx_data     = '0;
        host_tx_enable   = 1'b0;
        client_rx_enable = 1'b0;
        client_tx_data   = '0;
        client_tx_enable = 1'b0;
        repeat (4) @(negedge clk);
        resetb = 1'b1;
        @(negedge clk);
        check(host_tx_rdy, 0, "host_tx_rdy low after reset");
        check(client_rx_rdy, 0, "client_rx_rdy low after reset");
        check(status.tests_done, 0, "tests_done zero after reset");
        normal_passthrough();
        loopback_echo();
        source_burst();
        sink_consume();
        backpressure_drain();
        foreign_csr_write();
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/qa_drv_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host push has no back-pressure; watch host_rx_space
// Host and client drain through a rdy/enable pull
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "qa_drv_params.svh"

module qa_drv_top
(
    input  wire logic                       clk,
    input  wire logic                       resetb,

    // CSR write port
    input  wire logic                       csr_wr_valid,
    input  wire logic [15:0]                csr_wr_addr,
    input  wire logic [63:0]                csr_wr_data,

    // Host push into the host-to-client FIFO
    input  wire logic                       host_rx_valid,
    input  wire logic [`QA_UMF_WIDTH-1:0]   host_rx_data,
    output logic                            host_rx_space,

    // Host pull from the client-to-host FIFO
    output logic                            host_tx_rdy,
    output logic      [`QA_UMF_WIDTH-1:0]   host_tx_data,
    input  wire logic                       host_tx_enable,

    // Client ports
    output logic      [`QA_UMF_WIDTH-1:0]   client_rx_data,
    output logic                            client_rx_rdy,
    input  wire logic                       client_rx_enable,
    input  wire logic [`QA_UMF_WIDTH-1:0]   client_tx_data,
    output logic                            client_tx_rdy,
    input  wire logic                       client_tx_enable,

    output qa_drv_pkg::t_status             status
);

    qa_drv_pkg::t_csr_afu_state csr;
    qa_drv_pkg::t_tester_dbg    dbg;

    // Test node to FIFO wires
    logic [`QA_UMF_WIDTH-1:0] rx_data;
    logic                     rx_rdy;
    logic                     rx_enable;
    logic [`QA_UMF_WIDTH-1:0] tx_data;
    logic                     tx_rdy;
    logic                     tx_enable;
    logic                     test_done;

    qa_csr_decoder i_csr_decoder
    (
        .clk          (clk),
        .resetb       (resetb),
        .csr_wr_valid (csr_wr_valid),
        .csr_wr_addr  (csr_wr_addr),
        .csr_wr_data  (csr_wr_data),
        .csr          (csr)
    );

    // Host to client
    qa_chan_fifo #(.WIDTH(`QA_UMF_WIDTH), .DEPTH(`QA_FIFO_DEPTH)) i_rx_fifo
    (
        .clk       (clk),
        .resetb    (resetb),
        .wr_enable (host_rx_valid),
        .wr_data   (host_rx_data),
        .wr_rdy    (host_rx_space),
        .rd_data   (rx_data),
        .rd_rdy    (rx_rdy),
        .rd_enable (rx_enable)
    );

    // Client to host
    qa_chan_fifo #(.WIDTH(`QA_UMF_WIDTH), .DEPTH(`QA_FIFO_DEPTH)) i_tx_fifo
    (
        .clk       (clk),
        .resetb    (resetb),
        .wr_enable (tx_enable),
        .wr_data   (tx_data),
        .wr_rdy    (tx_rdy),
        .rd_data   (host_tx_data),
        .rd_rdy    (host_tx_rdy),
        .rd_enable (host_tx_enable)
    );

    qa_drv_tester i_tester
    (
        .clk              (clk),
        .resetb           (resetb),
        .csr              (csr),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_rdy    (client_tx_rdy),
        .client_tx_enable (client_tx_enable),
        .rx_data          (rx_data),
        .rx_rdy           (rx_rdy),
        .rx_enable        (rx_enable),
        .tx_data          (tx_data),
        .tx_enable        (tx_enable),
        .tx_rdy           (tx_rdy),
        .test_done        (test_done),
        .dbg              (dbg)
    );

    // Count only transfers the FIFOs actually accept
    qa_status_mgr i_status_mgr
    (
        .clk       (clk),
        .resetb    (resetb),
        .rx_pop    (rx_enable && rx_rdy),
        .tx_push   (tx_enable && tx_rdy),
        .test_done (test_done),
        .dbg_in    (dbg),
        .last_cfg  (csr.last_cfg),
        .status    (status)
    );

endmodule

`default_nettype wire

// File: source/qa_status_mgr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// All outputs lag their event by one edge
// Counters wrap without saturation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module qa_status_mgr
(
    input  wire logic                     clk,
    input  wire logic                     resetb,
    input  wire logic                     rx_pop,
    input  wire logic                     tx_push,
    input  wire logic                     test_done,
    input  qa_drv_pkg::t_tester_dbg       dbg_in,
    input  qa_drv_pkg::t_afu_enable_test  last_cfg,
    output qa_drv_pkg::t_status           status
);

    // Traffic counters
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            status.host_rx_msgs <= '0;
            status.host_tx_msgs <= '0;
        end
        else
        begin
            // Words taken out of the host-to-client FIFO
            if (rx_pop)
                status.host_rx_msgs <= status.host_rx_msgs + 1'b1;
            // Words written into the client-to-host FIFO
            if (tx_push)
                status.host_tx_msgs <= status.host_tx_msgs + 1'b1;
        end
    end

    // One increment per return to normal mode
    always_ff @(posedge clk)
    begin
        if (!resetb)
            status.tests_done <= '0;
        else if (test_done)
            status.tests_done <= status.tests_done + 1'b1;
    end

    // Snapshot of the handshake and the last request
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            status.dbg      <= '0;
            status.last_cfg <= '0;
        end
        else
        begin
            status.dbg      <= dbg_in;
            status.last_cfg <= last_cfg;
        end
    end

endmodule

`default_nettype wire

// File: source/qa_drv_tester.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Routing is combinational, only mode and source count are held
// Client is cut off while any test mode runs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "qa_drv_params.svh"

module qa_drv_tester
(
    input  wire logic                         clk,
    input  wire logic                         resetb,
    input  qa_drv_pkg::t_csr_afu_state        csr,

    // Client side of the host-to-client path
    output logic      [`QA_UMF_WIDTH-1:0]     client_rx_data,
    output logic                              client_rx_rdy,
    input  wire logic                         client_rx_enable,

    // Client side of the client-to-host path
    input  wire logic [`QA_UMF_WIDTH-1:0]     client_tx_data,
    output logic                              client_tx_rdy,
    input  wire logic                         client_tx_enable,

    // Host-to-client FIFO read side
    input  wire logic [`QA_UMF_WIDTH-1:0]     rx_data,
    input  wire logic                         rx_rdy,
    output logic                              rx_enable,

    // Client-to-host FIFO write side
    output logic      [`QA_UMF_WIDTH-1:0]     tx_data,
    output logic                              tx_enable,
    input  wire logic                         tx_rdy,

    output logic                              test_done,
    output qa_drv_pkg::t_tester_dbg           dbg
);

    qa_drv_pkg::t_test_mode mode;

    // Remaining words in source mode
    logic [30:0] source_count;
    logic        source_last;

    assign source_last = (source_count == 31'd1);

    always_comb
    begin
        // Client data wires always follow the FIFO, rdy decides ownership
        client_rx_data = rx_data;
        client_rx_rdy  = 1'b0;
        client_tx_rdy  = 1'b0;
        rx_enable      = 1'b0;
        tx_data        = client_tx_data;
        tx_enable      = 1'b0;
        test_done      = 1'b0;

        case (mode)
            qa_drv_pkg::MODE_SINK:
            begin
                // Only pop while the reply slot is free
                rx_enable = rx_rdy && tx_rdy;
                test_done = rx_enable && rx_data[0];
                // Single reply word of value 1 on the last message
                tx_data   = `QA_UMF_WIDTH'(1);
                tx_enable = test_done;
            end

            qa_drv_pkg::MODE_SOURCE:
            begin
                // Host input waits in its FIFO until the test ends
                tx_data   = {{(`QA_UMF_WIDTH-32){1'b0}}, source_count, source_last};
                tx_enable = tx_rdy;
                test_done = tx_rdy && source_last;
            end

            qa_drv_pkg::MODE_LOOPBACK:
            begin
                // Take a host word only if it can go straight back
                rx_enable = rx_rdy && tx_rdy;
                tx_data   = rx_data;
                tx_enable = rx_enable;
                test_done = rx_enable && rx_data[0];
            end

            default:
            begin
                // Normal pass-through between client and FIFOs
                client_rx_rdy = rx_rdy;
                rx_enable     = client_rx_enable;
                client_tx_rdy = tx_rdy;
                tx_enable     = client_tx_enable;
            end
        endcase
    end

    // Count preloads outside source mode; zero is run as one word
    always_ff @(posedge clk)
    begin
        if (mode != qa_drv_pkg::MODE_SOURCE)
        begin
            if (csr.last_cfg.count == '0)
                source_count <= 31'd1;
            else
                source_count <= csr.last_cfg.count;
        end
        else if (tx_rdy)
            source_count <= source_count - 1'b1;
    end

    // New request wins over a completion in the same cycle
    always_ff @(posedge clk)
    begin
        if (!resetb)
            mode <= qa_drv_pkg::MODE_NORMAL;
        else if (csr.afu_enable_test != '0)
            mode <= csr.afu_enable_test.test_state;
        else if (test_done)
            mode <= qa_drv_pkg::MODE_NORMAL;
    end

    // Raw handshake view, registered in the status manager
    always_comb
    begin
        dbg.rx_rdy    = rx_rdy;
        dbg.rx_enable = rx_enable;
        dbg.tx_rdy    = tx_rdy;
        dbg.tx_enable = tx_enable;
        dbg.mode      = mode;
    end

endmodule

`default_nettype wire

// File: source/qa_chan_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DEPTH must be a power of two, 2 or more
// Write while full is dropped; rdy rises one edge after a push
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module qa_chan_fifo
#(
    parameter int WIDTH = 128,
    parameter int DEPTH = 4
)
(
    input  wire logic             clk,
    input  wire logic             resetb,
    input  wire logic             wr_enable,
    input  wire logic [WIDTH-1:0] wr_data,
    output logic                  wr_rdy,
    output logic      [WIDTH-1:0] rd_data,
    output logic                  rd_rdy,
    input  wire logic             rd_enable
);

    localparam int PTR_W = $clog2(DEPTH);

    // Storage
    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // One extra bit so a full buffer is distinct from empty
    logic [PTR_W:0]   count;

    logic push;
    logic pop;

    assign wr_rdy  = (count != (PTR_W+1)'(DEPTH));
    assign rd_rdy  = (count != '0);
    assign rd_data = mem[rd_ptr];

    // Guard both sides so a stray enable cannot corrupt state
    assign push = wr_enable && wr_rdy;
    assign pop  = rd_enable && rd_rdy;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous push and pop leaves occupancy unchanged
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/qa_csr_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write-only CSR decode, no read path
// A request reaches the test node two edges after the strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "qa_drv_params.svh"

module qa_csr_decoder
(
    input  wire logic                       clk,
    input  wire logic                       resetb,
    input  wire logic                       csr_wr_valid,
    input  wire logic [15:0]                csr_wr_addr,
    input  wire logic [63:0]                csr_wr_data,
    output qa_drv_pkg::t_csr_afu_state      csr
);

    // Captured write, only the low 33 data bits matter
    logic        wr_valid_q;
    logic [15:0] wr_addr_q;
    logic [32:0] wr_data_q;

    // Decoded request from the captured write
    logic                         wr_hit;
    qa_drv_pkg::t_afu_enable_test wr_req;

    // First stage registers the raw write
    always_ff @(posedge clk)
    begin
        if (!resetb)
            wr_valid_q <= 1'b0;
        else
            wr_valid_q <= csr_wr_valid;
        wr_addr_q <= csr_wr_addr;
        wr_data_q <= csr_wr_data[32:0];
    end

    assign wr_hit = wr_valid_q && (wr_addr_q == `QA_CSR_ADDR_TEST);
    assign wr_req = qa_drv_pkg::t_afu_enable_test'(wr_data_q);

    // Second stage turns a hit into a one-cycle pulse
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            csr.afu_enable_test <= '0;
            csr.last_cfg        <= '0;
        end
        else
        begin
            // Pulse drops back to zero unless a new hit arrives
            csr.afu_enable_test <= wr_hit ? wr_req : '0;
            // Zero write is no request, so last_cfg keeps its value
            if (wr_hit && (wr_req != '0))
                csr.last_cfg <= wr_req;
        end
    end

endmodule

`default_nettype wire

// File: source/qa_drv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by the test node blocks
// An all-zero t_afu_enable_test means no request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "qa_drv_params.svh"

package qa_drv_pkg;

    // Test node operating mode
    typedef enum logic [1:0]
    {
        MODE_NORMAL   = `QA_MODE_NORMAL,
        MODE_SINK     = `QA_MODE_SINK,
        MODE_SOURCE   = `QA_MODE_SOURCE,
        MODE_LOOPBACK = `QA_MODE_LOOPBACK
    } t_test_mode;

    // Test request, the low 33 bits of a test-enable CSR write
    typedef struct packed
    {
        // Messages to send in source mode
        logic [30:0] count;
        t_test_mode  test_state;
    } t_afu_enable_test;

    // Decoder output to the test node
    typedef struct packed
    {
        // One-cycle request pulse
        t_afu_enable_test afu_enable_test;
        // Last accepted request, held
        t_afu_enable_test last_cfg;
    } t_csr_afu_state;

    // Handshake snapshot of the test node
    typedef struct packed
    {
        logic       rx_rdy;
        logic       rx_enable;
        logic       tx_rdy;
        logic       tx_enable;
        t_test_mode mode;
    } t_tester_dbg;

    // Counters and snapshot reported to the host side
    typedef struct packed
    {
        logic [15:0]      tests_done;
        logic [31:0]      host_rx_msgs;
        logic [31:0]      host_tx_msgs;
        t_tester_dbg      dbg;
        t_afu_enable_test last_cfg;
    } t_status;

endpackage

`default_nettype wire

// File: source/qa_drv_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared sizes and codes for the test node
// QA_FIFO_DEPTH must be a power of two, 2 or more
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef QA_DRV_PARAMS_SVH
`define QA_DRV_PARAMS_SVH

// One UMF message word
`define QA_UMF_WIDTH 128

// Entries in each channel FIFO
`define QA_FIFO_DEPTH 4

// Test-enable CSR, the only decoded write address
`define QA_CSR_ADDR_TEST 16'h0010

// Test node mode codes
`define QA_MODE_NORMAL   2'd0
`define QA_MODE_SINK     2'd1
`define QA_MODE_SOURCE   2'd2
`define QA_MODE_LOOPBACK 2'd3

`endif
